// File: compile.f
soc_map_pkg.sv
soc_io_pkg.sv
cpu_bus_front.sv
bus_decode.sv
ram_port.sv
eth_regs.sv
vsync_irq.sv
soc_io_top.sv
tb_soc_io.sv

// File: Makefile
# Verilator build and run of the io fabric testbench

VERILATOR ?= verilator
TOP ?= tb_soc_io
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep '\.sv$$' $(FILELIST))
BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_soc_io.sv
/* applies a table of Z80, download, mailbox and vsync operations to soc_io_top,
   then random RAM traffic checked against a byte model */
`timescale 1ns/1ps

module tb_soc_io
	import soc_map_pkg::*;
	import soc_io_pkg::*;
();

	localparam int OP_MEM_WR = 0, OP_MEM_RD = 1, OP_IO_WR = 2, OP_IO_RD = 3, OP_DL_WR = 4;
	localparam int OP_PUSH = 5, OP_POP = 6, OP_VSYNC = 7, OP_INTA = 8;
	localparam int N_RAND = 64;

	logic cpu_clock, cpu_reset;
	logic [ADDR_BITS-1:0] cpu_addr, dio_addr;
	logic [DATA_BITS-1:0] cpu_dout, cpu_din, dio_data, eth_tx_read_byte, eth_rx_write_byte;
	logic cpu_mreq_n, cpu_iorq_n, cpu_rd_n, cpu_wr_n, cpu_m1_n, cpu_wait_n, cpu_irq_n;
	logic dio_download, dio_write, eth_tx_read_strobe, eth_rx_write_strobe, video_vs;

	int op_kind [64];
	logic [ADDR_BITS-1:0] op_addr [64];
	logic [DATA_BITS-1:0] op_data [64];
	logic [DATA_BITS-1:0] op_exp [64];
	string op_name [64];
	int n_ops, n_checks, n_errors, i;
	logic [31:0] seed;
	logic [DATA_BITS-1:0] rdata, ram_model [32];
	logic model_valid [32];
	logic [ADDR_BITS-1:0] raddr;

	soc_io_top u_soc_io_top (.*);

	initial begin
		cpu_clock = 1'b0;
		forever #4 cpu_clock = ~cpu_clock;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic add_op(input int kind, input logic [15:0] addr, input logic [7:0] data,
		input logic [7:0] expected, input string name);
		op_kind[n_ops] = kind;
		op_addr[n_ops] = addr;
		op_data[n_ops] = data;
		op_exp[n_ops] = expected;
		op_name[n_ops] = name;
		n_ops++;
	endtask

	task automatic check_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
		end
	endtask

	// one Z80 memory or io cycle held until wait is released
	task automatic z80_cycle(input logic io, input logic we, input logic [15:0] addr,
		input logic [7:0] wdata, output logic [7:0] data);
		@(posedge cpu_clock);
		#1;
		cpu_addr = addr;
		cpu_dout = wdata;
		cpu_mreq_n = io;
		cpu_iorq_n = !io;
		cpu_rd_n = we;
		cpu_wr_n = !we;
		do begin
			@(posedge cpu_clock);
			#1;
		end while (!cpu_wait_n);
		data = cpu_din;
		cpu_mreq_n = 1'b1;
		cpu_iorq_n = 1'b1;
		cpu_rd_n = 1'b1;
		cpu_wr_n = 1'b1;
	endtask

	task automatic download_byte(input logic [15:0] addr, input logic [7:0] data,
		input string name);
		@(posedge cpu_clock);
		#1;
		dio_download = 1'b1;
		dio_addr = addr;
		dio_data = data;
		dio_write = 1'b1;
		@(posedge cpu_clock);
		#1;
		dio_write = 1'b0;
		repeat (4) @(posedge cpu_clock); // let the ram write finish
		#1;
		check_value(name, 8'h00, {7'b0, cpu_wait_n}); // cpu held off during download
		dio_download = 1'b0;
	endtask

	task automatic rx_push(input logic [7:0] data);
		@(posedge cpu_clock);
		#1;
		eth_rx_write_byte = data;
		eth_rx_write_strobe = 1'b1;
		@(posedge cpu_clock);
		#1;
		eth_rx_write_strobe = 1'b0;
	endtask

	task automatic tx_pop(input logic [7:0] expected, input string name);
		repeat (4) @(posedge cpu_clock); // posted io writes drain first
		#1;
		check_value(name, expected, eth_tx_read_byte);
		eth_tx_read_strobe = 1'b1;
		@(posedge cpu_clock);
		#1;
		eth_tx_read_strobe = 1'b0;
	endtask

	task automatic vsync_pulse(input logic [7:0] expected, input string name);
		@(posedge cpu_clock);
		#1;
		video_vs = 1'b1;
		repeat (2) @(posedge cpu_clock); // two sync flops
		#1;
		check_value(name, expected, {7'b0, cpu_irq_n});
		repeat (2) @(posedge cpu_clock);
		#1;
		video_vs = 1'b0;
		repeat (4) @(posedge cpu_clock);
		#1;
		check_value(name, expected, {7'b0, cpu_irq_n}); // still pending
	endtask

	task automatic int_ack_cycle(input logic [15:0] addr, input logic [7:0] expected,
		input string name);
		@(posedge cpu_clock);
		#1;
		cpu_addr = addr; // pc on the address bus during int-ack
		cpu_iorq_n = 1'b0;
		cpu_m1_n = 1'b0;
		repeat (2) @(posedge cpu_clock);
		#1;
		check_value(name, expected, {7'b0, cpu_irq_n});
		cpu_iorq_n = 1'b1;
		cpu_m1_n = 1'b1;
	endtask

	initial begin
		cpu_reset = 1'b1;
		{cpu_mreq_n, cpu_iorq_n, cpu_rd_n, cpu_wr_n, cpu_m1_n} = 5'b11111;
		cpu_addr = '0;
		cpu_dout = '0;
		{dio_download, dio_write, eth_tx_read_strobe, eth_rx_write_strobe, video_vs} = '0;
		dio_addr = '0;
		dio_data = '0;
		eth_rx_write_byte = '0;
		n_ops = 0;
		n_checks = 0;
		n_errors = 0;
		seed = 32'd97;
		for (i = 0; i < 32; i++)
			model_valid[i] = 1'b0;

		add_op(OP_DL_WR, 16'h0010, 8'hA5, 8'h00, "dl_rom0");
		add_op(OP_DL_WR, 16'h0011, 8'h3C, 8'h00, "dl_rom1");
		add_op(OP_MEM_RD, 16'h0010, 8'h00, 8'hA5, "rom_rd0");
		add_op(OP_MEM_RD, 16'h0011, 8'h00, 8'h3C, "rom_rd1");
		add_op(OP_MEM_WR, 16'h0010, 8'h77, 8'h00, "rom_wr");
		add_op(OP_MEM_RD, 16'h0010, 8'h00, 8'hA5, "rom_protect");
		add_op(OP_MEM_WR, 16'h8000, 8'h5A, 8'h00, "ram_wr0");
		add_op(OP_MEM_WR, 16'h8001, 8'hC3, 8'h00, "ram_wr1");
		add_op(OP_MEM_RD, 16'h8000, 8'h00, 8'h5A, "ram_rd0");
		add_op(OP_MEM_RD, 16'h8001, 8'h00, 8'hC3, "ram_rd1");
		for (i = 0; i <= ETH_BUF_DEPTH; i++) // one more than fits
			add_op(OP_IO_WR, 16'h1200 | ETH_REG_DATA, 8'h20 + 8'(i), 8'h00, "tx_fill");
		add_op(OP_IO_RD, ETH_REG_STATUS, 8'h00, 8'(ETH_BUF_DEPTH), "status_tx_full");
		for (i = 0; i < ETH_BUF_DEPTH; i++)
			add_op(OP_POP, 16'h0000, 8'h00, 8'h20 + 8'(i), "tx_order");
		add_op(OP_IO_RD, ETH_REG_STATUS, 8'h00, 8'h00, "status_tx_empty");
		for (i = 0; i < 3; i++)
			add_op(OP_PUSH, 16'h0000, 8'h81 + 8'(i), 8'h00, "rx_push");
		add_op(OP_IO_RD, ETH_REG_STATUS, 8'h00, 8'h30, "status_rx");
		for (i = 0; i < 3; i++)
			add_op(OP_IO_RD, ETH_REG_DATA, 8'h00, 8'h81 + 8'(i), "rx_order");
		add_op(OP_IO_RD, ETH_REG_DATA, 8'h00, 8'h00, "rx_empty");
		add_op(OP_PUSH, 16'h0000, 8'h44, 8'h00, "rx_push_one");
		add_op(OP_IO_WR, ETH_REG_DATA, 8'h55, 8'h00, "tx_one");
		add_op(OP_IO_RD, 16'h0005, 8'h00, 8'h00, "unknown_reg"); // both counts nonzero here
		add_op(OP_IO_RD, ETH_REG_STATUS, 8'h00, 8'h11, "status_pre_int");
		add_op(OP_VSYNC, 16'h0000, 8'h00, 8'h00, "irq_low");
		add_op(OP_INTA, ETH_REG_DATA, 8'h00, 8'h01, "irq_cleared");
		add_op(OP_IO_RD, ETH_REG_STATUS, 8'h00, 8'h11, "status_post_int");

		repeat (3) @(posedge cpu_clock);
		#1;
		cpu_reset = 1'b0;
		check_value("reset_wait", 8'h01, {7'b0, cpu_wait_n});
		check_value("reset_irq", 8'h01, {7'b0, cpu_irq_n});

		for (i = 0; i < n_ops; i++) begin
			case (op_kind[i])
				OP_MEM_WR: z80_cycle(1'b0, 1'b1, op_addr[i], op_data[i], rdata);
				OP_MEM_RD: begin
					z80_cycle(1'b0, 1'b0, op_addr[i], 8'h00, rdata);
					check_value(op_name[i], op_exp[i], rdata);
				end
				OP_IO_WR: z80_cycle(1'b1, 1'b1, op_addr[i], op_data[i], rdata);
				OP_IO_RD: begin
					z80_cycle(1'b1, 1'b0, op_addr[i], 8'h00, rdata);
					check_value(op_name[i], op_exp[i], rdata);
				end
				OP_DL_WR: download_byte(op_addr[i], op_data[i], op_name[i]);
				OP_PUSH: rx_push(op_data[i]);
				OP_POP: tx_pop(op_exp[i], op_name[i]);
				OP_VSYNC: vsync_pulse(op_exp[i], op_name[i]);
				OP_INTA: int_ack_cycle(op_addr[i], op_exp[i], op_name[i]);
				default: begin
					n_errors++;
					$display("unknown operation kind %0d in table entry %0d", op_kind[i], i);
				end
			endcase
		end

		// random ram traffic in a 32-byte window of the ram half
		for (i = 0; i < N_RAND; i++) begin
			seed = lcg_next(seed);
			raddr = 16'h8100 | {11'b0, seed[20:16]};
			if (seed[15] || !model_valid[raddr[4:0]]) begin
				z80_cycle(1'b0, 1'b1, raddr, seed[31:24], rdata);
				ram_model[raddr[4:0]] = seed[31:24];
				model_valid[raddr[4:0]] = 1'b1;
			end else begin
				z80_cycle(1'b0, 1'b0, raddr, 8'h00, rdata);
				check_value("rand_rd", ram_model[raddr[4:0]], rdata);
			end
		end

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// budget of 200 cycles per table entry and per random access
	initial begin
		#1;
		repeat ((n_ops + N_RAND) * 200) @(posedge cpu_clock);
		$display("timeout: the tests did not finish in %0d cycles", (n_ops + N_RAND) * 200);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: soc_io_top.sv
/* cpu-side io fabric: front stage, decode, ram, Ethernet mailbox and
   vsync interrupt wired together */
`timescale 1ns/1ps

module soc_io_top
	import soc_map_pkg::*;
(
	input logic cpu_clock,
	input logic cpu_reset,
	input logic [ADDR_BITS-1:0] cpu_addr,
	input logic [DATA_BITS-1:0] cpu_dout,
	input logic cpu_mreq_n,
	input logic cpu_iorq_n,
	input logic cpu_rd_n,
	input logic cpu_wr_n,
	input logic cpu_m1_n,
	output logic [DATA_BITS-1:0] cpu_din,
	output logic cpu_wait_n,
	output logic cpu_irq_n,
	input logic dio_download,
	input logic dio_write,
	input logic [ADDR_BITS-1:0] dio_addr,
	input logic [DATA_BITS-1:0] dio_data,
	input logic eth_tx_read_strobe,
	output logic [DATA_BITS-1:0] eth_tx_read_byte,
	input logic eth_rx_write_strobe,
	input logic [DATA_BITS-1:0] eth_rx_write_byte,
	input logic video_vs
);

	// front to decode
	logic req_valid, req_ready, req_we, req_io, req_cpu;
	logic [ADDR_BITS-1:0] req_addr;
	logic [DATA_BITS-1:0] req_data;
	logic rsp_valid;
	logic [DATA_BITS-1:0] rsp_data;
	logic int_ack;

	// Wishbone
	logic wb_cyc, wb_we, wb_cpu, ram_stb, eth_stb, ram_ack, eth_ack;
	logic [ADDR_BITS-1:0] wb_adr;
	logic [DATA_BITS-1:0] wb_dat_w, ram_dat_r, eth_dat_r;

	cpu_bus_front u_cpu_bus_front (.*);
	bus_decode u_bus_decode (.*);
	ram_port u_ram_port (.*);
	eth_regs u_eth_regs (.*);
	vsync_irq u_vsync_irq (.*);

endmodule

// File: vsync_irq.sv
/* vertical blank interrupt: syncs video_vs, latches its rising edge and
   drives cpu_irq_n until the interrupt-acknowledge cycle */
`timescale 1ns/1ps

module vsync_irq (
	input logic cpu_clock,
	input logic cpu_reset,
	input logic video_vs,
	input logic int_ack,
	output logic cpu_irq_n
);

	logic vs_s1, vs_s2;

	always_ff @(posedge cpu_clock) begin
		if (cpu_reset) begin
			vs_s1 <= 1'b0;
			vs_s2 <= 1'b0;
			cpu_irq_n <= 1'b1;
		end else begin
			vs_s1 <= video_vs; // vsync comes from the pixel clock domain
			vs_s2 <= vs_s1;
			if (int_ack)
				cpu_irq_n <= 1'b1; // ack wins over a new edge
			else if (vs_s1 && !vs_s2)
				cpu_irq_n <= 1'b0;
		end
	end

endmodule

// File: eth_regs.sv
/* Ethernet mailbox on Wishbone: tx and rx byte buffers shared with the io
   controller plus a status register holding both counts */
`timescale 1ns/1ps

module eth_regs
	import soc_map_pkg::*;
	import soc_io_pkg::*;
(
	input logic cpu_clock,
	input logic cpu_reset,
	input logic wb_cyc,
	input logic eth_stb,
	input logic wb_we,
	input logic [ADDR_BITS-1:0] wb_adr,
	input logic [DATA_BITS-1:0] wb_dat_w,
	input logic eth_tx_read_strobe,
	input logic eth_rx_write_strobe,
	input logic [DATA_BITS-1:0] eth_rx_write_byte,
	output logic [DATA_BITS-1:0] eth_dat_r,
	output logic eth_ack,
	output logic [DATA_BITS-1:0] eth_tx_read_byte
);

	logic [DATA_BITS-1:0] tx_buf [ETH_BUF_DEPTH];
	logic [DATA_BITS-1:0] rx_buf [ETH_BUF_DEPTH];
	logic [$clog2(ETH_BUF_DEPTH)-1:0] tx_wr, tx_rd, rx_wr, rx_rd;
	logic [ETH_CNT_BITS-1:0] tx_cnt, rx_cnt;
	logic access, sel_data, sel_status;
	logic tx_push, tx_pop, rx_push, rx_pop;

	assign access = wb_cyc && eth_stb && !eth_ack;
	assign sel_data = (wb_adr == ADDR_BITS'(ETH_REG_DATA));
	assign sel_status = (wb_adr == ADDR_BITS'(ETH_REG_STATUS));

	// full and empty pushes and pops are ignored
	assign tx_push = access && wb_we && sel_data && tx_cnt != ETH_CNT_BITS'(ETH_BUF_DEPTH);
	assign tx_pop = eth_tx_read_strobe && tx_cnt != '0;
	assign rx_push = eth_rx_write_strobe && rx_cnt != ETH_CNT_BITS'(ETH_BUF_DEPTH);
	assign rx_pop = access && !wb_we && sel_data && rx_cnt != '0;

	assign eth_tx_read_byte = tx_buf[tx_rd]; // head seen by the io controller

	always_ff @(posedge cpu_clock) begin
		if (cpu_reset) begin
			eth_ack <= 1'b0;
			tx_wr <= '0;
			tx_rd <= '0;
			rx_wr <= '0;
			rx_rd <= '0;
			tx_cnt <= '0;
			rx_cnt <= '0;
		end else begin
			eth_ack <= access;
			tx_wr <= tx_wr + tx_push;
			tx_rd <= tx_rd + tx_pop;
			rx_wr <= rx_wr + rx_push;
			rx_rd <= rx_rd + rx_pop;
			tx_cnt <= tx_cnt + ETH_CNT_BITS'(tx_push) - ETH_CNT_BITS'(tx_pop);
			rx_cnt <= rx_cnt + ETH_CNT_BITS'(rx_push) - ETH_CNT_BITS'(rx_pop);
		end
	end

	always_ff @(posedge cpu_clock) begin
		if (tx_push)
			tx_buf[tx_wr] <= wb_dat_w;
		if (rx_push)
			rx_buf[rx_wr] <= eth_rx_write_byte;
		if (access && !wb_we) begin
			if (sel_status)
				eth_dat_r <= {rx_cnt, tx_cnt};
			else if (rx_pop)
				eth_dat_r <= rx_buf[rx_rd];
			else
				eth_dat_r <= '0; // empty rx or unknown offset
		end
	end

	a_cnt_range: assert property (@(posedge cpu_clock) disable iff (cpu_reset)
		(tx_cnt <= ETH_CNT_BITS'(ETH_BUF_DEPTH)) && (rx_cnt <= ETH_CNT_BITS'(ETH_BUF_DEPTH)));

endmodule

// File: ram_port.sv
/* 64 KB byte memory on Wishbone with one wait state.
   cpu writes to the rom half are dropped, download writes are not */
`timescale 1ns/1ps

module ram_port
	import soc_map_pkg::*;
(
	input logic cpu_clock,
	input logic cpu_reset,
	input logic wb_cyc,
	input logic ram_stb,
	input logic wb_we,
	input logic [ADDR_BITS-1:0] wb_adr,
	input logic [DATA_BITS-1:0] wb_dat_w,
	input logic wb_cpu,
	output logic [DATA_BITS-1:0] ram_dat_r,
	output logic ram_ack
);

	logic [DATA_BITS-1:0] mem [0:(1 << ADDR_BITS)-1];
	logic access, rom_hit;

	assign access = wb_cyc && ram_stb && !ram_ack; // first strobe cycle
	assign rom_hit = !wb_adr[RAM_BASE_BIT];

	always_ff @(posedge cpu_clock) begin
		if (cpu_reset)
			ram_ack <= 1'b0;
		else
			ram_ack <= access; // ack on second strobe cycle
	end

	always_ff @(posedge cpu_clock) begin
		if (access) begin
			if (wb_we && !(rom_hit && wb_cpu))
				mem[wb_adr] <= wb_dat_w;
			ram_dat_r <= mem[wb_adr];
		end
	end

	a_ack_in_stb: assert property (@(posedge cpu_clock) disable iff (cpu_reset)
		ram_ack |-> (wb_cyc && ram_stb));

endmodule

// File: bus_decode.sv
/* decode stage: turns each front request into one Wishbone classic cycle
   on ram_port or eth_regs and returns read data to the front */
`timescale 1ns/1ps

module bus_decode
	import soc_map_pkg::*;
(
	input logic cpu_clock,
	input logic cpu_reset,
	input logic req_valid,
	input logic req_we,
	input logic req_io,
	input logic [ADDR_BITS-1:0] req_addr,
	input logic [DATA_BITS-1:0] req_data,
	input logic req_cpu,
	input logic [DATA_BITS-1:0] ram_dat_r,
	input logic ram_ack,
	input logic [DATA_BITS-1:0] eth_dat_r,
	input logic eth_ack,
	output logic req_ready,
	output logic wb_cyc,
	output logic wb_we,
	output logic [ADDR_BITS-1:0] wb_adr,
	output logic [DATA_BITS-1:0] wb_dat_w,
	output logic wb_cpu,
	output logic ram_stb,
	output logic eth_stb,
	output logic rsp_valid,
	output logic [DATA_BITS-1:0] rsp_data
);

	cpu_addr_t a;
	bus_target_e tgt; // TGT_NONE doubles as idle
	logic accept, ack;
	logic [DATA_BITS-1:0] dat_r;

	assign a = req_addr;
	assign req_ready = (tgt == TGT_NONE);
	assign accept = req_valid && req_ready;

	assign wb_cyc = (tgt != TGT_NONE);
	assign ram_stb = (tgt == TGT_RAM);
	assign eth_stb = (tgt == TGT_ETH);
	assign ack = (ram_stb && ram_ack) || (eth_stb && eth_ack);
	assign dat_r = ram_stb ? ram_dat_r : eth_dat_r;

	always_ff @(posedge cpu_clock) begin
		if (cpu_reset) begin
			tgt <= TGT_NONE;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			if (accept) begin
				tgt <= req_io ? TGT_ETH : TGT_RAM;
			end else if (ack) begin
				tgt <= TGT_NONE; // cyc and stb drop after ack
				rsp_valid <= !wb_we;
			end
		end
	end

	always_ff @(posedge cpu_clock) begin
		if (accept) begin
			wb_we <= req_we;
			wb_dat_w <= req_data;
			wb_cpu <= req_cpu;
			wb_adr <= req_io ? ADDR_BITS'(a.io.reg_idx) : a; // io uses the register index only
		end
		if (ack)
			rsp_data <= dat_r;
	end

	a_one_slave: assert property (@(posedge cpu_clock) disable iff (cpu_reset)
		!(ram_stb && eth_stb));

	a_stb_held: assert property (@(posedge cpu_clock) disable iff (cpu_reset)
		(wb_cyc && !ack) |=> $stable({ram_stb, eth_stb, wb_adr, wb_we}));

endmodule

// File: cpu_bus_front.sv
/* front stage of the io fabric: captures Z80 and download cycles as requests,
   drives wait and returns read data */
`timescale 1ns/1ps

module cpu_bus_front
	import soc_map_pkg::*;
(
	input logic cpu_clock,
	input logic cpu_reset,
	input logic [ADDR_BITS-1:0] cpu_addr,
	input logic [DATA_BITS-1:0] cpu_dout,
	input logic cpu_mreq_n,
	input logic cpu_iorq_n,
	input logic cpu_rd_n,
	input logic cpu_wr_n,
	input logic cpu_m1_n,
	input logic dio_download,
	input logic dio_write,
	input logic [ADDR_BITS-1:0] dio_addr,
	input logic [DATA_BITS-1:0] dio_data,
	input logic req_ready,
	input logic rsp_valid,
	input logic [DATA_BITS-1:0] rsp_data,
	output logic req_valid,
	output logic req_we,
	output logic req_io,
	output logic [ADDR_BITS-1:0] req_addr,
	output logic [DATA_BITS-1:0] req_data,
	output logic req_cpu,
	output logic [DATA_BITS-1:0] cpu_din,
	output logic cpu_wait_n,
	output logic int_ack
);

	logic mem_cyc, io_cyc, inta_cyc, active, active_d;
	logic cyc_new, cyc_req, slot_free;
	logic cpu_take, dio_take;
	logic cpu_pend; // cpu cycle seen but not yet in req
	logic rd_busy; // cpu read waiting for its response

	assign mem_cyc = !cpu_mreq_n && (!cpu_rd_n || !cpu_wr_n);
	assign io_cyc = !cpu_iorq_n && cpu_m1_n && (!cpu_rd_n || !cpu_wr_n);
	assign inta_cyc = !cpu_iorq_n && !cpu_m1_n;
	assign active = mem_cyc || io_cyc || inta_cyc;

	assign cyc_new = active && !active_d && !dio_download; // first clock of a cycle
	assign cyc_req = cyc_new && !inta_cyc;
	assign slot_free = !req_valid || req_ready;

	// download port owns the bus while it runs
	assign dio_take = dio_download && dio_write;
	assign cpu_take = !dio_download && (cyc_req || cpu_pend) && slot_free;

	// z80 bus keeps address and data stable while wait is low
	assign cpu_wait_n = !(dio_download || rd_busy || cpu_pend ||
		(cyc_req && (!cpu_rd_n || !slot_free)));

	always_ff @(posedge cpu_clock) begin
		if (cpu_reset) begin
			active_d <= 1'b0;
			cpu_pend <= 1'b0;
			rd_busy <= 1'b0;
			req_valid <= 1'b0;
			int_ack <= 1'b0;
		end else begin
			active_d <= active;
			cpu_pend <= (cyc_req || cpu_pend) && !cpu_take;
			int_ack <= cyc_new && inta_cyc;
			if (cyc_req && !cpu_rd_n)
				rd_busy <= 1'b1;
			else if (rsp_valid)
				rd_busy <= 1'b0; // wait released on the next clock
			if (cpu_take || dio_take)
				req_valid <= 1'b1;
			else if (req_ready)
				req_valid <= 1'b0;
		end
	end

	always_ff @(posedge cpu_clock) begin
		if (dio_take) begin
			req_we <= 1'b1;
			req_io <= 1'b0;
			req_addr <= dio_addr;
			req_data <= dio_data;
			req_cpu <= 1'b0;
		end else if (cpu_take) begin
			req_we <= !cpu_wr_n;
			req_io <= !cpu_iorq_n;
			req_addr <= cpu_addr;
			req_data <= cpu_dout;
			req_cpu <= 1'b1;
		end
		if (rsp_valid)
			cpu_din <= rsp_data;
	end

	// a read is never released before its data has come back
	a_read_waits: assert property (@(posedge cpu_clock) disable iff (cpu_reset)
		(rsp_valid || (req_valid && req_cpu && !req_we)) |-> !cpu_wait_n);

	// download strobes need a free request slot
	a_dio_slot: assert property (@(posedge cpu_clock) disable iff (cpu_reset)
		dio_take |-> slot_free);

endmodule

// File: soc_io_pkg.sv
/* Ethernet mailbox register offsets and buffer sizes.
   imported by eth_regs and by the testbench */
package soc_io_pkg;

	// register offsets within the io window
	localparam int ETH_REG_STATUS = 0; // rx count in high nibble and tx count in low
	localparam int ETH_REG_DATA = 1; // write pushes tx, read pops rx

	localparam int ETH_BUF_DEPTH = 8; // bytes per buffer
	localparam int ETH_CNT_BITS = 4; // wide enough for a full buffer

endpackage

// File: soc_map_pkg.sv
/* Z80 address map, address views and bus-target encoding.
   imported by the decode stage, the slaves and the top level */
package soc_map_pkg;

	localparam int ADDR_BITS = 16;
	localparam int DATA_BITS = 8;
	localparam int RAM_BASE_BIT = 15; // A15 low is the protected rom half

	// one address word, read as memory address or as io port
	typedef union packed {
		struct packed {
			logic ram; // A15
			logic [14:0] offset;
		} mem;
		struct packed {
			logic [7:0] high; // B register on in/out (c)
			logic [2:0] unused;
			logic [4:0] reg_idx;
		} io;
	} cpu_addr_t;

	// slave selected for the running Wishbone cycle
	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_RAM,
		TGT_ETH
	} bus_target_e;

endpackage
